// ==== src/xu_config.svh ====
/*
  xu execution slice configuration
  widths and sizes shared by decoder, micro-op queue and execute unit
*/
`ifndef XU_CONFIG_SVH
`define XU_CONFIG_SVH

`define XU_DATA_W 32      // data word
`define XU_INSN_W 32      // instruction word
`define XU_REG_CNT 16     // architectural registers

// queue entries, credits start here
`define XU_QUEUE_DEPTH 4

// must hold XU_QUEUE_DEPTH
`define XU_CREDIT_W 3

`endif

// ==== src/xu_isa_pkg.sv ====
/*
  xu instruction set encoding
  opcodes, condition codes and instruction field positions
*/
package xu_isa_pkg;

  typedef enum logic [3:0] {
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_and   = 4'd2,
    op_xor   = 4'd3,
    op_or    = 4'd4,
    op_shl   = 4'd5,
    op_shr   = 4'd6,
    op_sar   = 4'd7,
    op_sxtb  = 4'd8,
    op_sxth  = 4'd9,
    op_bswap = 4'd10,
    op_movi  = 4'd11,
    op_addi  = 4'd12,
    op_cmp   = 4'd13,
    op_ill_e = 4'd14,  // illegal
    op_ill_f = 4'd15   // illegal
  } opcode_e;

  typedef enum logic [3:0] {
    cond_eq, cond_ne,
    cond_cs, cond_cc,
    cond_mi, cond_pl,
    cond_vs, cond_vc,
    cond_hi, cond_ls,
    cond_ge, cond_lt,
    cond_gt, cond_le,
    cond_al, cond_nv
  } cond_e;

  typedef logic [11:0] imm_t;

  // low bit of each field in the instruction word
  localparam int op_lsb   = 28;
  localparam int cond_lsb = 24;
  localparam int rd_lsb   = 20;
  localparam int ra_lsb   = 16;
  localparam int rb_lsb   = 12;
  localparam int imm_lsb  = 0;

endpackage

// ==== src/xu_exec_pkg.sv ====
/*
  xu execution side types
  data word, register index and condition flag set
*/
`include "xu_config.svh"

package xu_exec_pkg;

  typedef logic [`XU_DATA_W-1:0] data_t;

  typedef logic [$clog2(`XU_REG_CNT)-1:0] reg_idx_t;

  // carry is the msb
  typedef struct packed {
    logic carry;
    logic overflow;
    logic negative;
    logic zero;
  } flags_t;

endpackage

// ==== src/xu_alu.sv ====
/*
  integer ALU
  result and condition flags for one micro-op, purely combinational
*/
`timescale 1ns/10ps
`include "xu_config.svh"

module xu_alu (
  input  xu_isa_pkg::opcode_e op,
  input  xu_exec_pkg::data_t  a,
  input  xu_exec_pkg::data_t  b,
  input  xu_exec_pkg::data_t  imm,
  output xu_exec_pkg::data_t  result,
  output xu_exec_pkg::flags_t flags
);
  import xu_isa_pkg::*;
  import xu_exec_pkg::*;

  localparam int w = `XU_DATA_W;
  localparam int sh_w = $clog2(w);

  data_t addend;
  logic carry_in;
  logic [w:0] sum;
  logic arith;
  data_t swapped;

  always_comb begin
    addend = b;
    carry_in = 1'b0;
    case (op)
      op_addi: addend = imm;
      op_sub, op_cmp: begin
        addend = ~b;  // a - b as a + ~b + 1
        carry_in = 1'b1;
      end
      default: ;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, addend} + {{w{1'b0}}, carry_in};
  assign arith = op inside {op_add, op_sub, op_addi, op_cmp};

  always_comb begin
    for (int i = 0; i < w / 8; i++)
      swapped[8*i +: 8] = a[w-8-8*i +: 8];
  end

  always_comb begin
    case (op)
      op_add, op_sub, op_addi, op_cmp: result = sum[w-1:0];
      op_and:   result = a & b;
      op_xor:   result = a ^ b;
      op_or:    result = a | b;
      op_shl:   result = a << b[sh_w-1:0];
      op_shr:   result = a >> b[sh_w-1:0];
      op_sar:   result = $signed(a) >>> b[sh_w-1:0];
      op_sxtb:  result = {{(w-8){a[7]}}, a[7:0]};
      op_sxth:  result = {{(w-16){a[15]}}, a[15:0]};
      op_bswap: result = swapped;
      op_movi:  result = imm;
      default:  result = '0;  // illegal
    endcase
  end

  always_comb begin
    flags.carry = arith && sum[w];
    // operands agree in sign, result does not
    flags.overflow = arith && (a[w-1] == addend[w-1]) && (sum[w-1] != a[w-1]);
    flags.negative = result[w-1];
    flags.zero = (result == '0);
  end

endmodule

// ==== src/insn_decoder.sv ====
/*
  instruction decoder
  splits instruction words into micro-op fields, forces illegal opcodes
  to a never condition and pushes into the micro-op queue against credits
*/
`timescale 1ns/10ps
`include "xu_config.svh"

module insn_decoder (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  insn_valid,
  input  logic [`XU_INSN_W-1:0] insn,
  output logic                  insn_ready,
  input  logic                  credit_return,
  output logic                  push,
  output xu_isa_pkg::opcode_e   uop_op,
  output xu_isa_pkg::cond_e     uop_cond,
  output xu_exec_pkg::reg_idx_t uop_rd,
  output xu_exec_pkg::reg_idx_t uop_ra,
  output xu_exec_pkg::reg_idx_t uop_rb,
  output xu_exec_pkg::data_t    uop_imm
);
  import xu_isa_pkg::*;
  import xu_exec_pkg::*;

  localparam int unsigned credit_w = `XU_CREDIT_W;
  localparam int unsigned imm_w = $bits(imm_t);

  logic stage_valid;
  logic [credit_w-1:0] credits;
  logic accept;
  opcode_e dec_op;
  imm_t dec_imm;
  logic dec_illegal;

  assign dec_op = opcode_e'(insn[op_lsb +: $bits(opcode_e)]);
  assign dec_imm = insn[imm_lsb +: imm_w];
  assign dec_illegal = (dec_op == op_ill_e) || (dec_op == op_ill_f);

  assign push = stage_valid && (credits != '0);  // one slot is free in the queue
  assign insn_ready = !stage_valid || push;
  assign accept = insn_valid && insn_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
      credits <= credit_w'(`XU_QUEUE_DEPTH);
    end else begin
      if (accept)
        stage_valid <= 1'b1;
      else if (push)
        stage_valid <= 1'b0;

      case ({push, credit_return})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;  // none or both
      endcase
    end
  end

  // staged micro-op
  always_ff @(posedge clk) begin
    if (accept) begin
      uop_op <= dec_op;
      uop_cond <= dec_illegal ? cond_nv : cond_e'(insn[cond_lsb +: $bits(cond_e)]);
      uop_rd <= insn[rd_lsb +: $bits(reg_idx_t)];
      uop_ra <= insn[ra_lsb +: $bits(reg_idx_t)];
      uop_rb <= insn[rb_lsb +: $bits(reg_idx_t)];
      uop_imm <= {{(`XU_DATA_W - imm_w){dec_imm[imm_w-1]}}, dec_imm};
    end
  end

endmodule

// ==== src/uop_queue.sv ====
/*
  micro-op queue
  circular buffer between decoder and execute unit, one credit back per pop
*/
`timescale 1ns/10ps
`include "xu_config.svh"

module uop_queue #(
  parameter int depth = `XU_QUEUE_DEPTH  // power of two
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  xu_isa_pkg::opcode_e   uop_op,
  input  xu_isa_pkg::cond_e     uop_cond,
  input  xu_exec_pkg::reg_idx_t uop_rd,
  input  xu_exec_pkg::reg_idx_t uop_ra,
  input  xu_exec_pkg::reg_idx_t uop_rb,
  input  xu_exec_pkg::data_t    uop_imm,
  output logic                  not_empty,
  output xu_isa_pkg::opcode_e   head_op,
  output xu_isa_pkg::cond_e     head_cond,
  output xu_exec_pkg::reg_idx_t head_rd,
  output xu_exec_pkg::reg_idx_t head_ra,
  output xu_exec_pkg::reg_idx_t head_rb,
  output xu_exec_pkg::data_t    head_imm,
  input  logic                  pop,
  output logic                  credit_return
);
  import xu_isa_pkg::*;
  import xu_exec_pkg::*;

  localparam int ptr_w = $clog2(depth);

  opcode_e  op_mem   [depth];
  cond_e    cond_mem [depth];
  reg_idx_t rd_mem   [depth];
  reg_idx_t ra_mem   [depth];
  reg_idx_t rb_mem   [depth];
  data_t    imm_mem  [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0] count;

  assign not_empty = (count != '0);
  assign head_op = op_mem[rd_ptr];
  assign head_cond = cond_mem[rd_ptr];
  assign head_rd = rd_mem[rd_ptr];
  assign head_ra = ra_mem[rd_ptr];
  assign head_rb = rb_mem[rd_ptr];
  assign head_imm = imm_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_return <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr] <= uop_op;
      cond_mem[wr_ptr] <= uop_cond;
      rd_mem[wr_ptr] <= uop_rd;
      ra_mem[wr_ptr] <= uop_ra;
      rb_mem[wr_ptr] <= uop_rb;
      imm_mem[wr_ptr] <= uop_imm;
    end
  end

endmodule

// ==== src/exec_unit.sv ====
/*
  execute unit
  register file and flags, predicated execution through the ALU,
  one result register held until the consumer takes it
*/
`timescale 1ns/10ps
`include "xu_config.svh"

module exec_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  not_empty,
  input  xu_isa_pkg::opcode_e   head_op,
  input  xu_isa_pkg::cond_e     head_cond,
  input  xu_exec_pkg::reg_idx_t head_rd,
  input  xu_exec_pkg::reg_idx_t head_ra,
  input  xu_exec_pkg::reg_idx_t head_rb,
  input  xu_exec_pkg::data_t    head_imm,
  output logic                  pop,
  output logic                  res_valid,
  input  logic                  res_ready,
  output xu_exec_pkg::reg_idx_t res_rd,
  output xu_exec_pkg::data_t    res_data,
  output xu_exec_pkg::flags_t   res_flags,
  output logic                  res_skip
);
  import xu_isa_pkg::*;
  import xu_exec_pkg::*;

  data_t regs [`XU_REG_CNT];
  flags_t flags;
  data_t opa;
  data_t opb;
  data_t old_rd;
  data_t alu_result;
  flags_t alu_flags;
  logic cond_ok;

  function automatic logic cond_holds(input cond_e cond, input flags_t f);
    logic ge;
    ge = (f.negative == f.overflow);
    case (cond)
      cond_eq: cond_holds = f.zero;
      cond_ne: cond_holds = !f.zero;
      cond_cs: cond_holds = f.carry;
      cond_cc: cond_holds = !f.carry;
      cond_mi: cond_holds = f.negative;
      cond_pl: cond_holds = !f.negative;
      cond_vs: cond_holds = f.overflow;
      cond_vc: cond_holds = !f.overflow;
      cond_hi: cond_holds = f.carry && !f.zero;
      cond_ls: cond_holds = !(f.carry && !f.zero);
      cond_ge: cond_holds = ge;
      cond_lt: cond_holds = !ge;
      cond_gt: cond_holds = ge && !f.zero;
      cond_le: cond_holds = !(ge && !f.zero);
      cond_al: cond_holds = 1'b1;
      default: cond_holds = 1'b0;  // nv
    endcase
  endfunction

  assign opa = regs[head_ra];
  assign opb = regs[head_rb];
  assign old_rd = regs[head_rd];
  assign cond_ok = cond_holds(head_cond, flags);

  // take the next uop when the result slot frees up this cycle
  assign pop = not_empty && (!res_valid || res_ready);

  xu_alu i_alu (
    .op     (head_op),
    .a      (opa),
    .b      (opb),
    .imm    (head_imm),
    .result (alu_result),
    .flags  (alu_flags)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `XU_REG_CNT; i++)
        regs[i] <= '0;
      flags <= '0;
      res_valid <= 1'b0;
    end else begin
      if (pop) begin
        res_valid <= 1'b1;
        if (cond_ok) begin
          flags <= alu_flags;
          if (head_op != op_cmp)
            regs[head_rd] <= alu_result;  // cmp only sets flags
        end
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
    end
  end

  // cmp reports the difference, a skip reports old rd and current flags
  always_ff @(posedge clk) begin
    if (pop) begin
      res_rd <= head_rd;
      res_skip <= !cond_ok;
      res_data <= cond_ok ? alu_result : old_rd;
      res_flags <= cond_ok ? alu_flags : flags;
    end
  end

endmodule

// ==== src/xu_top.sv ====
/*
  xu execution slice top
  decoder feeds the micro-op queue on credits, execute unit drains it
*/
`timescale 1ns/10ps
`include "xu_config.svh"

module xu_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  insn_valid,
  input  logic [`XU_INSN_W-1:0] insn,
  output logic                  insn_ready,
  output logic                  res_valid,
  input  logic                  res_ready,
  output xu_exec_pkg::reg_idx_t res_rd,
  output xu_exec_pkg::data_t    res_data,
  output xu_exec_pkg::flags_t   res_flags,
  output logic                  res_skip
);
  import xu_isa_pkg::*;
  import xu_exec_pkg::*;

  logic push;
  logic pop;
  logic not_empty;
  logic credit_return;
  opcode_e uop_op;
  opcode_e head_op;
  cond_e uop_cond;
  cond_e head_cond;
  reg_idx_t uop_rd;
  reg_idx_t uop_ra;
  reg_idx_t uop_rb;
  reg_idx_t head_rd;
  reg_idx_t head_ra;
  reg_idx_t head_rb;
  data_t uop_imm;
  data_t head_imm;

  insn_decoder i_decoder (
    .clk           (clk),
    .rst           (rst),
    .insn_valid    (insn_valid),
    .insn          (insn),
    .insn_ready    (insn_ready),
    .credit_return (credit_return),
    .push          (push),
    .uop_op        (uop_op),
    .uop_cond      (uop_cond),
    .uop_rd        (uop_rd),
    .uop_ra        (uop_ra),
    .uop_rb        (uop_rb),
    .uop_imm       (uop_imm)
  );

  uop_queue i_queue (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .uop_op        (uop_op),
    .uop_cond      (uop_cond),
    .uop_rd        (uop_rd),
    .uop_ra        (uop_ra),
    .uop_rb        (uop_rb),
    .uop_imm       (uop_imm),
    .not_empty     (not_empty),
    .head_op       (head_op),
    .head_cond     (head_cond),
    .head_rd       (head_rd),
    .head_ra       (head_ra),
    .head_rb       (head_rb),
    .head_imm      (head_imm),
    .pop           (pop),
    .credit_return (credit_return)
  );

  exec_unit i_exec (
    .clk       (clk),
    .rst       (rst),
    .not_empty (not_empty),
    .head_op   (head_op),
    .head_cond (head_cond),
    .head_rd   (head_rd),
    .head_ra   (head_ra),
    .head_rb   (head_rb),
    .head_imm  (head_imm),
    .pop       (pop),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_rd    (res_rd),
    .res_data  (res_data),
    .res_flags (res_flags),
    .res_skip  (res_skip)
  );

endmodule

// ==== tests/xu_checker.sv ====
/*
  xu slice protocol checker
  bound to xu_top, watches credits, queue occupancy and result hold
*/
`timescale 1ns/10ps
`include "xu_config.svh"

module xu_checker (
  input logic                       clk,
  input logic                       rst,
  input logic [`XU_CREDIT_W-1:0]    credits,
  input logic                       push,
  input logic [$clog2(`XU_QUEUE_DEPTH):0] count,
  input logic                       insn_valid,
  input logic                       insn_ready,
  input logic                       res_valid,
  input logic                       res_ready,
  input xu_exec_pkg::reg_idx_t      res_rd,
  input xu_exec_pkg::data_t         res_data,
  input xu_exec_pkg::flags_t        res_flags,
  input logic                       res_skip
);
  int outstanding;  // accepted but not yet taken

  always_ff @(posedge clk) begin
    if (rst)
      outstanding <= 0;
    else
      outstanding <= outstanding + (insn_valid && insn_ready) - (res_valid && res_ready);
  end

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= `XU_QUEUE_DEPTH) else $error("credit counter above queue depth");

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> (count != `XU_QUEUE_DEPTH)) else $error("push into a full queue");

  a_result_hold: assert property (@(posedge clk) disable iff (rst)
    (res_valid && !res_ready) |=> (res_valid && $stable(res_rd) && $stable(res_data)
      && $stable(res_flags) && $stable(res_skip))) else $error("result changed while stalled");

  a_result_origin: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> (outstanding > 0)) else $error("result without an accepted instruction");

endmodule

bind xu_top xu_checker i_checker (
  .clk        (clk),
  .rst        (rst),
  .credits    (i_decoder.credits),
  .push       (push),
  .count      (i_queue.count),
  .insn_valid (insn_valid),
  .insn_ready (insn_ready),
  .res_valid  (res_valid),
  .res_ready  (res_ready),
  .res_rd     (res_rd),
  .res_data   (res_data),
  .res_flags  (res_flags),
  .res_skip   (res_skip)
);

// ==== tests/xu_tb.sv ====
/*
  xu slice testbench
  offers a table of instructions, collects results under random
  back-pressure and compares them in order
*/
`timescale 1ns/10ps
`include "xu_config.svh"

module xu_tb;
  logic clk;
  logic rst;
  logic insn_valid;
  logic [`XU_INSN_W-1:0] insn;
  logic insn_ready;
  logic res_valid;
  logic res_ready;
  logic [3:0] res_rd;
  logic [31:0] res_data;
  logic [3:0] res_flags;  // carry, overflow, negative, zero
  logic res_skip;

  logic [31:0] tab_insn [$];
  logic [3:0] tab_rd [$];
  logic [31:0] tab_data [$];
  logic [3:0] tab_flags [$];
  logic tab_skip [$];
  string tab_name [$];
  int value_errs;
  int other_errs;
  bit saw_stall;

  xu_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .insn_ready (insn_ready),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_rd     (res_rd),
    .res_data   (res_data),
    .res_flags  (res_flags),
    .res_skip   (res_skip)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] encode_insn(input int op, input int cond, input int rd,
                                              input int ra, input int rb, input int imm);
    encode_insn = {op[3:0], cond[3:0], rd[3:0], ra[3:0], rb[3:0], imm[11:0]};
  endfunction

  task automatic add_case(input string name, input int op, input int cond, input int rd,
                          input int ra, input int rb, input int imm, input logic [31:0] data,
                          input logic [3:0] flags, input logic skip);
    tab_insn.push_back(encode_insn(op, cond, rd, ra, rb, imm));
    tab_rd.push_back(rd[3:0]);
    tab_data.push_back(data);
    tab_flags.push_back(flags);
    tab_skip.push_back(skip);
    tab_name.push_back(name);
  endtask

  task automatic build_table();
    // opcodes movi 11, addi 12, cmp 13 and conditions al 14, nv 15
    add_case("movi_pos", 11, 14, 1, 0, 0, 'h005, 32'h5, 4'h0, 0);
    add_case("movi_neg", 11, 14, 2, 0, 0, 'hfff, 32'hffffffff, 4'h2, 0);
    add_case("addi", 12, 14, 3, 1, 0, 'h7ff, 32'h804, 4'h0, 0);
    add_case("add_carry", 0, 14, 4, 1, 2, 0, 32'h4, 4'h8, 0);
    add_case("sub_zero", 1, 14, 5, 1, 1, 0, 32'h0, 4'h9, 0);
    add_case("and", 2, 14, 6, 3, 2, 0, 32'h804, 4'h0, 0);
    add_case("xor", 3, 14, 7, 1, 2, 0, 32'hfffffffa, 4'h2, 0);
    add_case("or", 4, 14, 8, 1, 3, 0, 32'h805, 4'h0, 0);
    add_case("movi_shamt", 11, 14, 9, 0, 0, 'h004, 32'h4, 4'h0, 0);
    add_case("shl", 5, 14, 10, 1, 9, 0, 32'h50, 4'h0, 0);
    add_case("shr", 6, 14, 11, 2, 9, 0, 32'h0fffffff, 4'h0, 0);
    add_case("sar", 7, 14, 12, 7, 9, 0, 32'hffffffff, 4'h2, 0);
    add_case("sxtb", 8, 14, 13, 7, 0, 0, 32'hfffffffa, 4'h2, 0);
    add_case("sxth", 9, 14, 14, 11, 0, 0, 32'hffffffff, 4'h2, 0);
    add_case("bswap", 10, 14, 15, 3, 0, 0, 32'h04080000, 4'h0, 0);
    add_case("movi_one", 11, 14, 0, 0, 0, 'h001, 32'h1, 4'h0, 0);
    add_case("shr_max", 6, 14, 0, 2, 0, 0, 32'h7fffffff, 4'h0, 0);
    add_case("add_ovf", 0, 14, 0, 0, 0, 0, 32'hfffffffe, 4'h6, 0);
    // flags now n and v set
    add_case("skip_eq", 11, 0, 1, 0, 0, 'h111, 32'h5, 4'h6, 1);
    add_case("skip_cs", 11, 2, 1, 0, 0, 'h111, 32'h5, 4'h6, 1);
    add_case("skip_pl", 11, 5, 1, 0, 0, 'h111, 32'h5, 4'h6, 1);
    add_case("skip_vc", 11, 7, 1, 0, 0, 'h111, 32'h5, 4'h6, 1);
    add_case("skip_hi", 11, 8, 1, 0, 0, 'h111, 32'h5, 4'h6, 1);
    add_case("skip_lt", 11, 11, 1, 0, 0, 'h111, 32'h5, 4'h6, 1);
    add_case("skip_nv", 11, 15, 1, 0, 0, 'h111, 32'h5, 4'h6, 1);
    add_case("cmp_ge", 13, 10, 4, 1, 1, 0, 32'h0, 4'h9, 0);
    // flags now c and z set
    add_case("skip_ne", 11, 1, 4, 0, 0, 'h222, 32'h4, 4'h9, 1);
    add_case("skip_cc", 11, 3, 4, 0, 0, 'h222, 32'h4, 4'h9, 1);
    add_case("skip_mi", 11, 4, 4, 0, 0, 'h222, 32'h4, 4'h9, 1);
    add_case("skip_vs", 11, 6, 4, 0, 0, 'h222, 32'h4, 4'h9, 1);
    add_case("skip_hi2", 11, 8, 4, 0, 0, 'h222, 32'h4, 4'h9, 1);
    add_case("skip_gt", 11, 12, 4, 0, 0, 'h222, 32'h4, 4'h9, 1);
    add_case("or_ls", 4, 9, 3, 4, 4, 0, 32'h4, 4'h0, 0);  // r4 kept by cmp
    add_case("skip_le", 11, 13, 3, 0, 0, 'h333, 32'h4, 4'h0, 1);
    add_case("movi_pl", 11, 5, 1, 0, 0, 'h123, 32'h123, 4'h0, 0);
    add_case("movi_cc", 11, 3, 9, 0, 0, 'h800, 32'hfffff800, 4'h2, 0);
    add_case("xor_mi", 3, 4, 8, 8, 8, 0, 32'h0, 4'h1, 0);
    add_case("illegal_14", 14, 14, 8, 0, 0, 0, 32'h0, 4'h1, 1);
    add_case("illegal_15", 15, 14, 2, 0, 0, 0, 32'hffffffff, 4'h1, 1);
  endtask

  task automatic drive_insns();
    int t;
    for (int i = 0; i < tab_insn.size(); i++) begin
      @(negedge clk);
      insn_valid = 1'b1;
      insn = tab_insn[i];
      t = 0;
      while (!insn_ready && t < 200) begin
        saw_stall = 1'b1;
        @(negedge clk);
        t++;
      end
      if (!insn_ready) begin
        $display("timeout: instruction %0d was never accepted", i);
        other_errs++;
        return;
      end
    end
    @(negedge clk);
    insn_valid = 1'b0;
  endtask

  task automatic collect_results();
    int idx;
    int cyc;
    int idle;
    idx = 0;
    cyc = 0;
    idle = 0;
    while (idx < tab_insn.size()) begin
      @(negedge clk);
      cyc++;
      res_ready = (cyc < 20) ? 1'b0 : 1'($urandom % 2);  // hold off first to fill the queue
      if (res_valid && res_ready) begin
        if (res_rd !== tab_rd[idx]) begin
          $display("ERR %s rd expected %0d actual %0d", tab_name[idx], tab_rd[idx], res_rd);
          value_errs++;
        end
        if (res_data !== tab_data[idx]) begin
          $display("ERR %s data expected %h actual %h", tab_name[idx], tab_data[idx],
                   res_data);
          value_errs++;
        end
        if (res_flags !== tab_flags[idx]) begin
          $display("ERR %s flags expected %b actual %b", tab_name[idx], tab_flags[idx],
                   res_flags);
          value_errs++;
        end
        if (res_skip !== tab_skip[idx]) begin
          $display("ERR %s skip expected %b actual %b", tab_name[idx], tab_skip[idx],
                   res_skip);
          value_errs++;
        end
        idx++;
        idle = 0;
      end else begin
        idle++;
        if (idle > 200) begin
          $display("timeout: result %0d never arrived", idx);
          other_errs++;
          return;
        end
      end
    end
    // nothing extra may follow
    repeat (10) begin
      @(negedge clk);
      if (res_valid) begin
        $display("extra result seen after the last table entry");
        other_errs++;
        return;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    res_ready = 1'b0;
    value_errs = 0;
    other_errs = 0;
    saw_stall = 1'b0;
    void'($urandom(32'he49d));
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fork
      drive_insns();
      collect_results();
    join
    if (!saw_stall) begin
      $display("insn_ready never fell while the queue was backed up");
      other_errs++;
    end
    $display("value errors %0d, other errors %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+src
src/xu_isa_pkg.sv
src/xu_exec_pkg.sv
src/xu_alu.sv
src/insn_decoder.sv
src/uop_queue.sv
src/exec_unit.sv
src/xu_top.sv
tests/xu_checker.sv
tests/xu_tb.sv
